//--- verilog/core_pkg.sv
package core_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;

	localparam addr_t RESET_PC = 32'h20000000;

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B // pass-b for lui
	} alu_op_t;

	typedef enum logic [2:0] {
		CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_ILLEGAL
	} inst_class_t;

	typedef enum logic [2:0] {
		FETCH, WAIT_INST, EXEC, MEM, WB
	} ctrl_state_t;

	typedef struct packed {
		addr_t      addr;
		xlen_t      wdata;
		logic [3:0] wstrb;
		logic       write;
	} mem_req_t;

	typedef struct packed {
		xlen_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		xlen_t       imm;
		alu_op_t     alu_op;
		inst_class_t inst_class;
		logic [2:0]  funct3;
		logic        a_pc;   // operand a is pc
		logic        b_imm;  // operand b is imm
		logic        reg_we;
	} dec_t;

endpackage

//--- verilog/core_regfile.sv
`timescale 1ns/1ns
module core_regfile import core_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output xlen_t    rdata1,
	output xlen_t    rdata2,
	input  logic     wen,
	input  reg_idx_t waddr,
	input  xlen_t    wdata
);

	xlen_t regs [1:31]; // x0 has no storage

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

//--- verilog/core_decode.sv
`timescale 1ns/1ns
module core_decode import core_pkg::*; (
	input  inst_t inst,
	output dec_t  dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	xlen_t      imm_i;
	xlen_t      imm_s;
	xlen_t      imm_b;
	xlen_t      imm_u;
	xlen_t      imm_j;
	logic       alt_ok;
	logic       f7_ok;
	logic       need_f7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct7 legality for register and shift forms
	assign alt_ok  = (funct7 == 7'h20) &&
		((funct3 == 3'b000 && opcode == OP_REG) || funct3 == 3'b101);
	assign f7_ok   = (funct7 == 7'h00) || alt_ok;
	assign need_f7 = (opcode == OP_REG) || (funct3 == 3'b001) || (funct3 == 3'b101);

	always_comb begin
		dec            = '0;
		dec.rd         = inst[11:7];
		dec.rs1        = inst[19:15];
		dec.rs2        = inst[24:20];
		dec.funct3     = funct3;
		dec.alu_op     = ALU_ADD;
		dec.inst_class = CLS_ILLEGAL;
		case (opcode)
			OP_LUI: begin
				dec.inst_class = CLS_ALU;
				dec.alu_op     = ALU_PASS_B;
				dec.imm        = imm_u;
				dec.b_imm      = 1'b1;
				dec.reg_we     = 1'b1;
			end
			OP_AUIPC: begin
				dec.inst_class = CLS_ALU;
				dec.imm        = imm_u;
				dec.a_pc       = 1'b1;
				dec.b_imm      = 1'b1;
				dec.reg_we     = 1'b1;
			end
			OP_JAL: begin
				dec.inst_class = CLS_JAL;
				dec.imm        = imm_j;
				dec.reg_we     = 1'b1;
			end
			OP_JALR: begin
				dec.imm = imm_i;
				if (funct3 == 3'b000) begin
					dec.inst_class = CLS_JALR;
					dec.reg_we     = 1'b1;
				end
			end
			OP_BRANCH: begin
				dec.imm = imm_b;
				if (funct3 != 3'b010 && funct3 != 3'b011) begin
					dec.inst_class = CLS_BRANCH;
				end
			end
			OP_LOAD: begin
				dec.imm   = imm_i;
				dec.b_imm = 1'b1;
				if (funct3 == 3'b010) begin // lw only
					dec.inst_class = CLS_LOAD;
					dec.reg_we     = 1'b1;
				end
			end
			OP_STORE: begin
				dec.imm   = imm_s;
				dec.b_imm = 1'b1;
				if (funct3 == 3'b010) begin
					dec.inst_class = CLS_STORE;
				end
			end
			OP_IMM, OP_REG: begin
				dec.imm   = imm_i;
				dec.b_imm = (opcode == OP_IMM);
				case (funct3)
					3'b000: dec.alu_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
					3'b001: dec.alu_op = ALU_SLL;
					3'b010: dec.alu_op = ALU_SLT;
					3'b011: dec.alu_op = ALU_SLTU;
					3'b100: dec.alu_op = ALU_XOR;
					3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
					3'b110: dec.alu_op = ALU_OR;
					default: dec.alu_op = ALU_AND;
				endcase
				if (!need_f7 || f7_ok) begin
					dec.inst_class = CLS_ALU;
					dec.reg_we     = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- verilog/core_execute.sv
`timescale 1ns/1ns
module core_execute import core_pkg::*; (
	input  dec_t  dec,
	input  addr_t pc,
	input  xlen_t rs1_data,
	input  xlen_t rs2_data,
	output xlen_t alu_result,
	output addr_t next_pc,
	output addr_t mem_addr
);

	xlen_t      op_a;
	xlen_t      op_b;
	xlen_t      alu_out;
	logic [4:0] shamt;
	addr_t      snpc;
	addr_t      pc_target;
	addr_t      jalr_target;
	logic       taken;

	assign op_a  = dec.a_pc ? pc : rs1_data;
	assign op_b  = dec.b_imm ? dec.imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_SLL:    alu_out = op_a << shamt;
			ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SRL:    alu_out = op_a >> shamt;
			ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
			ALU_OR:     alu_out = op_a | op_b;
			ALU_AND:    alu_out = op_a & op_b;
			default:    alu_out = op_b; // lui
		endcase
	end

	assign snpc        = pc + 32'd4;
	assign pc_target   = pc + dec.imm;
	assign jalr_target = (rs1_data + dec.imm) & ~32'd1;
	assign mem_addr    = rs1_data + dec.imm;

	always_comb begin
		case (dec.funct3)
			3'b000:  taken = (rs1_data == rs2_data);
			3'b001:  taken = (rs1_data != rs2_data);
			3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
			3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
			3'b110:  taken = (rs1_data < rs2_data);
			3'b111:  taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.inst_class)
			CLS_JAL:    next_pc = pc_target;
			CLS_JALR:   next_pc = jalr_target;
			CLS_BRANCH: next_pc = taken ? pc_target : snpc;
			default:    next_pc = snpc;
		endcase
	end

	// link address for jumps
	assign alu_result = (dec.inst_class == CLS_JAL || dec.inst_class == CLS_JALR) ?
		snpc : alu_out;

endmodule

//--- verilog/core_result.sv
`timescale 1ns/1ns
module core_result import core_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  dec_t     dec,
	input  xlen_t    alu_result,
	input  addr_t    mem_addr,
	input  xlen_t    rs2_data,
	input  logic     mem_start,
	input  logic     wb_stage,
	output logic     dmem_req_valid,
	output mem_req_t dmem_req,
	input  logic     dmem_req_ready,
	input  logic     dmem_rsp_valid,
	input  mem_rsp_t dmem_rsp,
	output logic     mem_done,
	output logic     wb_en,
	output xlen_t    wb_data
);

	logic  pending; // request sent, response not yet seen
	xlen_t load_data;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dmem_req_valid <= 1'b0;
			pending        <= 1'b0;
		end else begin
			if (mem_start) begin
				dmem_req_valid <= 1'b1;
			end else if (dmem_req_valid && dmem_req_ready) begin
				dmem_req_valid <= 1'b0;
			end
			if (dmem_req_valid && dmem_req_ready) begin
				pending <= 1'b1;
			end else if (dmem_rsp_valid) begin
				pending <= 1'b0;
			end
		end
	end

	// payload held until handshake
	always_ff @(posedge clock) begin
		if (mem_start) begin
			dmem_req.addr  <= mem_addr;
			dmem_req.wdata <= rs2_data;
			dmem_req.wstrb <= 4'hf;
			dmem_req.write <= (dec.inst_class == CLS_STORE);
		end
		if (dmem_rsp_valid && pending) begin
			load_data <= dmem_rsp.rdata;
		end
	end

	assign mem_done = dmem_rsp_valid && pending;

	assign wb_en   = wb_stage && dec.reg_we && (dec.rd != '0);
	assign wb_data = (dec.inst_class == CLS_LOAD) ? load_data : alu_result;

endmodule

//--- verilog/core_control.sv
`timescale 1ns/1ns
module core_control import core_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  dec_t     dec,
	input  addr_t    next_pc,
	input  logic     mem_done,
	input  logic     wb_en,
	input  xlen_t    wb_data,
	output logic     ifetch_req_valid,
	output mem_req_t ifetch_req,
	input  logic     ifetch_req_ready,
	input  logic     ifetch_rsp_valid,
	input  mem_rsp_t ifetch_rsp,
	output inst_t    inst,
	output addr_t    pc,
	output logic     mem_start,
	output logic     wb_stage,
	output logic     retire_valid,
	output addr_t    retire_pc,
	output reg_idx_t retire_rd,
	output xlen_t    retire_data
);

	ctrl_state_t state;
	logic        is_mem;

	assign is_mem = (dec.inst_class == CLS_LOAD) || (dec.inst_class == CLS_STORE);

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state            <= FETCH;
			pc               <= RESET_PC;
			ifetch_req_valid <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					if (ifetch_req_valid && ifetch_req_ready) begin
						ifetch_req_valid <= 1'b0;
						state            <= WAIT_INST;
					end else begin
						ifetch_req_valid <= 1'b1;
					end
				end
				WAIT_INST: if (ifetch_rsp_valid) state <= EXEC;
				EXEC:      state <= is_mem ? MEM : WB;
				MEM:       if (mem_done) state <= WB;
				default: begin // WB
					pc               <= next_pc;
					ifetch_req_valid <= 1'b1; // no bubble before next fetch
					state            <= FETCH;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == WAIT_INST && ifetch_rsp_valid) begin
			inst <= ifetch_rsp.rdata;
		end
	end

	always_comb begin
		ifetch_req       = '0;
		ifetch_req.addr  = pc;
		ifetch_req.write = 1'b0;
	end

	assign mem_start = (state == EXEC) && is_mem;
	assign wb_stage  = (state == WB);

	assign retire_valid = wb_stage;
	assign retire_pc    = pc;
	assign retire_rd    = wb_en ? dec.rd : '0;
	assign retire_data  = wb_en ? wb_data : '0;

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ns
module core_top import core_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,

	output logic     ifetch_req_valid,
	output mem_req_t ifetch_req,
	input  logic     ifetch_req_ready,
	input  logic     ifetch_rsp_valid,
	input  mem_rsp_t ifetch_rsp,

	output logic     dmem_req_valid,
	output mem_req_t dmem_req,
	input  logic     dmem_req_ready,
	input  logic     dmem_rsp_valid,
	input  mem_rsp_t dmem_rsp,

	output logic     retire_valid,
	output addr_t    retire_pc,
	output reg_idx_t retire_rd,
	output xlen_t    retire_data
);

	inst_t inst;
	dec_t  dec;
	addr_t pc;
	addr_t next_pc;
	addr_t mem_addr;
	xlen_t rs1_data;
	xlen_t rs2_data;
	xlen_t alu_result;
	xlen_t wb_data;
	logic  mem_start;
	logic  mem_done;
	logic  wb_stage;
	logic  wb_en;

	core_control control_inst (
		.clock(clock), .arst_n(arst_n), .dec(dec), .next_pc(next_pc),
		.mem_done(mem_done), .wb_en(wb_en), .wb_data(wb_data),
		.ifetch_req_valid(ifetch_req_valid), .ifetch_req(ifetch_req),
		.ifetch_req_ready(ifetch_req_ready), .ifetch_rsp_valid(ifetch_rsp_valid),
		.ifetch_rsp(ifetch_rsp), .inst(inst), .pc(pc),
		.mem_start(mem_start), .wb_stage(wb_stage),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	core_decode decode_inst (.inst(inst), .dec(dec));

	core_regfile regfile_inst (
		.clock(clock), .arst_n(arst_n),
		.raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_data), .rdata2(rs2_data),
		.wen(wb_en), .waddr(dec.rd), .wdata(wb_data)
	);

	core_execute execute_inst (
		.dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.alu_result(alu_result), .next_pc(next_pc), .mem_addr(mem_addr)
	);

	core_result result_inst (
		.clock(clock), .arst_n(arst_n), .dec(dec), .alu_result(alu_result),
		.mem_addr(mem_addr), .rs2_data(rs2_data),
		.mem_start(mem_start), .wb_stage(wb_stage),
		.dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
		.dmem_req_ready(dmem_req_ready), .dmem_rsp_valid(dmem_rsp_valid),
		.dmem_rsp(dmem_rsp), .mem_done(mem_done), .wb_en(wb_en), .wb_data(wb_data)
	);

endmodule

//--- testbench/core_chk.sv
`timescale 1ns/1ns
module core_chk import core_pkg::*; (
	input logic     clock,
	input logic     arst_n,
	input logic     ifetch_req_valid,
	input mem_req_t ifetch_req,
	input logic     ifetch_req_ready,
	input logic     ifetch_rsp_valid,
	input logic     dmem_req_valid,
	input mem_req_t dmem_req,
	input logic     dmem_req_ready,
	input logic     dmem_rsp_valid,
	input logic     retire_valid
);

	logic if_open; // fetch accepted, answer not yet back
	logic dm_open;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			if_open <= 1'b0;
			dm_open <= 1'b0;
		end else begin
			if (ifetch_req_valid && ifetch_req_ready) begin
				if_open <= 1'b1;
			end else if (ifetch_rsp_valid) begin
				if_open <= 1'b0;
			end
			if (dmem_req_valid && dmem_req_ready) begin
				dm_open <= 1'b1;
			end else if (dmem_rsp_valid) begin
				dm_open <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!arst_n)
		ifetch_req_valid && !ifetch_req_ready |=> ifetch_req_valid && $stable(ifetch_req))
		else $error("fetch request dropped or changed while waiting for ready");

	assert property (@(posedge clock) disable iff (!arst_n)
		dmem_req_valid && !dmem_req_ready |=> dmem_req_valid && $stable(dmem_req))
		else $error("data request dropped or changed while waiting for ready");

	assert property (@(posedge clock) disable iff (!arst_n) !(ifetch_req_valid && if_open))
		else $error("second fetch request while one is outstanding");

	assert property (@(posedge clock) disable iff (!arst_n) !(dmem_req_valid && dm_open))
		else $error("second data request while one is outstanding");

	assert property (@(posedge clock) disable iff (!arst_n) retire_valid |=> !retire_valid)
		else $error("retire_valid high on two consecutive cycles");

	assert property (@(posedge clock) !arst_n |-> !ifetch_req_valid && !dmem_req_valid)
		else $error("request valid during reset");

endmodule

bind core_top core_chk chk_inst (
	.clock(clock),
	.arst_n(arst_n),
	.ifetch_req_valid(ifetch_req_valid),
	.ifetch_req(ifetch_req),
	.ifetch_req_ready(ifetch_req_ready),
	.ifetch_rsp_valid(ifetch_rsp_valid),
	.dmem_req_valid(dmem_req_valid),
	.dmem_req(dmem_req),
	.dmem_req_ready(dmem_req_ready),
	.dmem_rsp_valid(dmem_rsp_valid),
	.retire_valid(retire_valid)
);

//--- testbench/core_tb.sv
`timescale 1ns/1ns
module core_tb import core_pkg::*; ();

	logic     clock;
	logic     arst_n;
	logic     ifetch_req_valid;
	mem_req_t ifetch_req;
	logic     ifetch_req_ready;
	logic     ifetch_rsp_valid;
	mem_rsp_t ifetch_rsp;
	logic     dmem_req_valid;
	mem_req_t dmem_req;
	logic     dmem_req_ready;
	logic     dmem_rsp_valid;
	mem_rsp_t dmem_rsp;
	logic     retire_valid;
	addr_t    retire_pc;
	reg_idx_t retire_rd;
	xlen_t    retire_data;

	xlen_t       vec [0:255];
	xlen_t       mem [0:1023];
	logic [31:0] lfsr;
	int          n_prog;
	int          n_retire;
	int          n_store;
	int          ret_base;
	int          st_base;
	int          ridx;
	int          sidx;
	int          retire_errs;
	int          store_errs;
	int          other_errs;

	// index 0 is the fetch port and 1 the data port
	int    rdy_wait [2];
	int    rsp_wait [2];
	logic  busy [2];
	logic  rdy_next [2];
	logic  rsp_next [2];
	xlen_t word_next [2];

	core_top core_top_inst (
		.clock(clock), .arst_n(arst_n),
		.ifetch_req_valid(ifetch_req_valid), .ifetch_req(ifetch_req),
		.ifetch_req_ready(ifetch_req_ready), .ifetch_rsp_valid(ifetch_rsp_valid),
		.ifetch_rsp(ifetch_rsp),
		.dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
		.dmem_req_ready(dmem_req_ready), .dmem_rsp_valid(dmem_rsp_valid),
		.dmem_rsp(dmem_rsp),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic draw_delay(output int d);
		logic [1:0] b;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
		d = int'(b);
	endtask

	task automatic check_word(input string name, input xlen_t exp, input xlen_t act,
		input bit store_side);
		assert (act === exp) else begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			if (store_side) begin
				store_errs++;
			end else begin
				retire_errs++;
			end
		end
	endtask

	task automatic check_retire();
		int b;
		b = ret_base + 3 * ridx;
		check_word($sformatf("retire %0d pc", ridx), vec[b], retire_pc, 1'b0);
		check_word($sformatf("retire %0d rd", ridx), vec[b + 1], {27'b0, retire_rd}, 1'b0);
		check_word($sformatf("retire %0d data", ridx), vec[b + 2], retire_data, 1'b0);
		ridx++;
	endtask

	task automatic serve_access(input int p, input mem_req_t req);
		int b;
		b = st_base + 2 * sidx;
		if (p == 0) begin
			check_word($sformatf("fetch %h write flag", req.addr), 32'h0,
				{31'b0, req.write}, 1'b0);
		end else begin
			check_word($sformatf("data %h strobe", req.addr), 32'hf,
				{28'b0, req.wstrb}, 1'b1);
		end
		if (p == 1 && req.write) begin
			if (sidx < n_store) begin
				check_word($sformatf("store %0d addr", sidx), vec[b], req.addr, 1'b1);
				check_word($sformatf("store %0d data", sidx), vec[b + 1], req.wdata, 1'b1);
			end else begin
				$display("Store to %h with data %h comes after the last expected store",
					req.addr, req.wdata);
				store_errs++;
			end
			sidx++;
			mem[req.addr[11:2]] = req.wdata;
		end
		word_next[p] = mem[req.addr[11:2]]; // store ack carries the written word
	endtask

	task automatic step_port(input int p, input logic valid, input logic ready,
		input mem_req_t req);
		int d;
		rsp_next[p] = 1'b0;
		if (valid && ready) begin
			serve_access(p, req);
			draw_delay(d);
			rsp_wait[p] = d + 1; // 1 to 4 cycles
			busy[p]     = 1'b1;
			draw_delay(d);
			rdy_wait[p] = d;
		end else if (valid && rdy_wait[p] > 0) begin
			rdy_wait[p]--;
		end
		if (busy[p]) begin
			rsp_wait[p]--;
			if (rsp_wait[p] == 0) begin
				rsp_next[p] = 1'b1;
				busy[p]     = 1'b0;
			end
		end
		rdy_next[p] = (rdy_wait[p] == 0);
	endtask

	task automatic finish_run();
		$display("retire errors %0d, store errors %0d, other errors %0d",
			retire_errs, store_errs, other_errs);
		if (retire_errs + store_errs + other_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		if (retire_valid && ridx < n_retire) begin
			check_retire();
		end
	end

	initial begin : memory_model
		forever begin
			@(posedge clock);
			step_port(0, ifetch_req_valid, ifetch_req_ready, ifetch_req);
			step_port(1, dmem_req_valid, dmem_req_ready, dmem_req);
			#5;
			ifetch_req_ready = rdy_next[0];
			ifetch_rsp_valid = rsp_next[0];
			ifetch_rsp.rdata = word_next[0];
			dmem_req_ready   = rdy_next[1];
			dmem_rsp_valid   = rsp_next[1];
			dmem_rsp.rdata   = word_next[1];
		end
	end

	initial begin : main_sequence
		arst_n           = 1'b0;
		ifetch_req_ready = 1'b0;
		ifetch_rsp_valid = 1'b0;
		ifetch_rsp       = '0;
		dmem_req_ready   = 1'b0;
		dmem_rsp_valid   = 1'b0;
		dmem_rsp         = '0;
		lfsr             = 32'ha072a423;
		ridx             = 0;
		sidx             = 0;
		retire_errs      = 0;
		store_errs       = 0;
		other_errs       = 0;
		for (int p = 0; p < 2; p++) begin
			rdy_wait[p]  = 0;
			rsp_wait[p]  = 0;
			busy[p]      = 1'b0;
			rdy_next[p]  = 1'b0;
			rsp_next[p]  = 1'b0;
			word_next[p] = '0;
		end
		$readmemh("testbench/core_vectors.txt", vec);
		n_prog   = int'(vec[0]);
		n_retire = int'(vec[1]);
		n_store  = int'(vec[2]);
		ret_base = 3 + n_prog;
		st_base  = ret_base + 3 * n_retire;
		for (int i = 0; i < 1024; i++) begin
			mem[i] = (RESET_PC + 32'(i * 4)) ^ 32'h5a5a5a5a;
		end
		for (int i = 0; i < n_prog; i++) begin
			mem[i] = vec[3 + i]; // word 0 sits at RESET_PC
		end
		if (n_retire == 0) begin
			$display("No retire records were read from the vectors file");
			other_errs++;
		end
		repeat (10) @(posedge clock);
		#5;
		arst_n = 1'b1;
		wait (ridx == n_retire);
		@(posedge clock);
		if (sidx != n_store) begin
			$display("Only %0d of %0d expected stores reached the data port", sidx, n_store);
			store_errs++;
		end
		finish_run();
	end

	initial begin : watchdog
		@(posedge arst_n);
		repeat (40 * n_retire) @(posedge clock);
		$display("Core stopped retiring after %0d of %0d expected instructions",
			ridx, n_retire);
		other_errs++;
		finish_run();
	end

endmodule

//--- testbench/core_vectors.txt
// counts: program words, retire records, store records; then program words from RESET_PC
// then retire records (pc rd data) and store records (addr data)
0000001f 0000001a 00000003
200000b7 ffb00113 00700193 40218233 40115293 00312333 003133b3 00001417
1040a023 1050a223 1000a483 1040a503 00518013 009005b3 00448463 00100613
00449463 00314463 00200613 00316463 00c006ef 00300613 00400613 06908767
00500613 00600613 1000a423 00e6c7b3 0f017813 00419893 0000006f
// retire trace
20000000 01 20000000  20000004 02 fffffffb
20000008 03 00000007  2000000c 04 0000000c
20000010 05 fffffffd  20000014 06 00000001
20000018 07 00000000  2000001c 08 2000101c
20000020 00 00000000  20000024 00 00000000
20000028 09 0000000c  2000002c 0a fffffffd
20000030 00 00000000  20000034 0b 0000000c
20000038 00 00000000  20000040 00 00000000
20000044 00 00000000  2000004c 00 00000000
20000050 0d 20000054  2000005c 0e 20000060
20000068 00 00000000  2000006c 0f 00000034
20000070 10 000000f0  20000074 11 00000070
20000078 00 00000000  20000078 00 00000000
// store trace
20000100 0000000c  20000104 fffffffd  20000108 00000000

//--- tb.f
verilog/core_pkg.sv
verilog/core_regfile.sv
verilog/core_decode.sv
verilog/core_execute.sv
verilog/core_result.sv
verilog/core_control.sv
verilog/core_top.sv
testbench/core_chk.sv
testbench/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
